//--- design/ee_bus_arbiter.sv
`timescale 1ns/1ps
`include "eeprom_config.svh"

module ee_bus_arbiter
    import eeprom_pkg::*;
(
    input  logic                     CLK,
    input  logic                     RESET,
    input  logic [`EE_NUM_PORTS-1:0] head_valid,
    input  ee_req_t                  head [`EE_NUM_PORTS],
    output logic [`EE_NUM_PORTS-1:0] pop,
    output logic                     grant_valid,
    output ee_grant_t                grant,
    input  logic                     seq_ready,
    input  logic                     done_valid,
    input  ee_rsp_t                  done_rsp,
    input  ee_port_t                 done_port,
    output logic [`EE_NUM_PORTS-1:0] rsp_valid,
    output ee_rsp_t                  rsp [`EE_NUM_PORTS]
);

    logic     busy;     // sequencer owns a request
    ee_port_t last;
    ee_port_t sel;
    logic     transfer;
    logic     pick;

    // round robin between the two heads
    always_comb begin
        if (head_valid[0] && head_valid[1]) begin
            sel = ~last;
        end else if (head_valid[1]) begin
            sel = 1'b1;
        end else begin
            sel = 1'b0;
        end
    end

    assign transfer = grant_valid && seq_ready;
    assign pick     = !grant_valid && !busy && (|head_valid);

    always_ff @(posedge CLK) begin
        if (RESET) begin
            grant_valid <= 1'b0;
            busy        <= 1'b0;
            last        <= 1'b1; // port 0 wins the first tie
        end else begin
            if (transfer) begin
                grant_valid <= 1'b0;
                busy        <= 1'b1;
                last        <= grant.port;
            end else if (pick) begin
                grant_valid <= 1'b1;
            end
            if (done_valid) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (pick) begin
            grant.req  <= head[sel];
            grant.port <= sel;
        end
    end

    always_comb begin
        for (int p = 0; p < `EE_NUM_PORTS; p++) begin
            pop[p]       = transfer && (grant.port == ee_port_t'(p));
            rsp_valid[p] = done_valid && (done_port == ee_port_t'(p));
            rsp[p]       = done_rsp;
        end
    end

    a_done_while_busy: assert property (@(posedge CLK) disable iff (RESET)
        done_valid |-> busy);

endmodule

//--- design/ee_req_queue.sv
`timescale 1ns/1ps
`include "eeprom_config.svh"

module ee_req_queue
    import eeprom_pkg::*;
(
    input  logic    CLK,
    input  logic    RESET,
    input  logic    push,
    input  ee_req_t push_req,
    output logic    head_valid,
    output ee_req_t head,
    input  logic    pop,
    output logic    credit_return
);

    localparam int unsigned PTR_W = $clog2(`EE_QUEUE_DEPTH);
    localparam int unsigned CNT_W = $clog2(`EE_QUEUE_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_IDX = PTR_W'(`EE_QUEUE_DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(`EE_QUEUE_DEPTH);

    ee_req_t          mem [`EE_QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    assign head_valid = (count != '0);
    assign head       = mem[rd_ptr];

    always_ff @(posedge CLK) begin
        if (push) begin
            mem[wr_ptr] <= push_req;
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_IDX) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_IDX) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            credit_return <= pop; // one credit back per popped entry
        end
    end

    // requester must hold a credit, so a full queue never sees a push
    a_no_push_full: assert property (@(posedge CLK) disable iff (RESET)
        push |-> (count != FULL_CNT));

    a_no_pop_empty: assert property (@(posedge CLK) disable iff (RESET)
        pop |-> head_valid);

endmodule

//--- design/eeprom_config.svh
`ifndef EEPROM_CONFIG_SVH
`define EEPROM_CONFIG_SVH

// peer requesters sharing the bus
`define EE_NUM_PORTS 2

// entries per request queue, also the starting credit count
`define EE_QUEUE_DEPTH 4

// CLK cycles per SCL half period
`define EE_SCL_DIV 4

// fixed upper nibble of the 24Cxx control byte
`define EE_DEV_CODE 4'b1010

`endif

//--- design/eeprom_ctrl_top.sv
`timescale 1ns/1ps
`include "eeprom_config.svh"

module eeprom_ctrl_top
    import eeprom_pkg::*;
(
    input  logic                     CLK,
    input  logic                     RESET,
    input  logic [`EE_NUM_PORTS-1:0] req_valid,
    input  ee_req_t                  req [`EE_NUM_PORTS],
    output logic [`EE_NUM_PORTS-1:0] credit_return,
    output logic [`EE_NUM_PORTS-1:0] rsp_valid,
    output ee_rsp_t                  rsp [`EE_NUM_PORTS],
    output logic                     scl,
    output logic                     sda_drive_low,
    input  logic                     sda_in
);

    logic [`EE_NUM_PORTS-1:0] head_valid;
    ee_req_t                  head [`EE_NUM_PORTS];
    logic [`EE_NUM_PORTS-1:0] pop;
    logic                     grant_valid;
    ee_grant_t                grant;
    logic                     seq_ready;
    logic                     done_valid;
    ee_rsp_t                  done_rsp;
    ee_port_t                 done_port;
    logic                     cmd_valid;
    bit_cmd_e                 cmd;
    ee_data_t                 cmd_byte;
    logic                     cmd_done;
    logic                     ack_seen;
    ee_data_t                 rx_byte;

    for (genvar p = 0; p < `EE_NUM_PORTS; p++) begin : g_queue
        ee_req_queue queue_i (
            .CLK           (CLK),
            .RESET         (RESET),
            .push          (req_valid[p]),
            .push_req      (req[p]),
            .head_valid    (head_valid[p]),
            .head          (head[p]),
            .pop           (pop[p]),
            .credit_return (credit_return[p])
        );
    end

    ee_bus_arbiter arb_i (
        .CLK         (CLK),
        .RESET       (RESET),
        .head_valid  (head_valid),
        .head        (head),
        .pop         (pop),
        .grant_valid (grant_valid),
        .grant       (grant),
        .seq_ready   (seq_ready),
        .done_valid  (done_valid),
        .done_rsp    (done_rsp),
        .done_port   (done_port),
        .rsp_valid   (rsp_valid),
        .rsp         (rsp)
    );

    eeprom_txn_seq seq_i (
        .CLK         (CLK),
        .RESET       (RESET),
        .grant_valid (grant_valid),
        .grant       (grant),
        .seq_ready   (seq_ready),
        .done_valid  (done_valid),
        .done_rsp    (done_rsp),
        .done_port   (done_port),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .cmd_byte    (cmd_byte),
        .cmd_done    (cmd_done),
        .ack_seen    (ack_seen),
        .rx_byte     (rx_byte)
    );

    i2c_bit_engine bit_i (
        .CLK           (CLK),
        .RESET         (RESET),
        .cmd_valid     (cmd_valid),
        .cmd           (cmd),
        .cmd_byte      (cmd_byte),
        .cmd_done      (cmd_done),
        .ack_seen      (ack_seen),
        .rx_byte       (rx_byte),
        .scl           (scl),
        .sda_drive_low (sda_drive_low),
        .sda_in        (sda_in)
    );

endmodule

//--- design/eeprom_pkg.sv
package eeprom_pkg;

    typedef logic [10:0] ee_addr_t; // [10:8] ride in the control byte
    typedef logic [7:0]  ee_data_t;
    typedef logic        ee_port_t;

    typedef struct packed {
        logic     write;
        ee_addr_t addr;
        ee_data_t wdata;
    } ee_req_t;

    typedef struct packed {
        logic     write;
        logic     err;   // device nack seen
        ee_addr_t addr;
        ee_data_t rdata;
    } ee_rsp_t;

    typedef struct packed {
        ee_req_t  req;
        ee_port_t port;
    } ee_grant_t;

    typedef enum logic [2:0] {
        cmd_idle,
        cmd_start,
        cmd_stop,
        cmd_wr_byte,
        cmd_rd_byte_ack,
        cmd_rd_byte_nack
    } bit_cmd_e;

    typedef enum logic [3:0] {
        ts_idle,
        ts_start,
        ts_ctrl_wr,
        ts_addr,
        ts_data_wr,
        ts_rstart,
        ts_ctrl_rd,
        ts_data_rd,
        ts_stop,
        ts_respond
    } txn_state_e;

    typedef enum logic [2:0] {
        bs_idle,
        bs_start,
        bs_stop,
        bs_shift,
        bs_ack
    } bit_state_e;

endpackage

//--- design/eeprom_txn_seq.sv
`timescale 1ns/1ps
`include "eeprom_config.svh"

module eeprom_txn_seq
    import eeprom_pkg::*;
(
    input  logic      CLK,
    input  logic      RESET,
    input  logic      grant_valid,
    input  ee_grant_t grant,
    output logic      seq_ready,
    output logic      done_valid,
    output ee_rsp_t   done_rsp,
    output ee_port_t  done_port,
    output logic      cmd_valid,
    output bit_cmd_e  cmd,
    output ee_data_t  cmd_byte,
    input  logic      cmd_done,
    input  logic      ack_seen,
    input  ee_data_t  rx_byte
);

    txn_state_e state;
    logic       waiting;  // command issued, engine busy
    logic       nack_err;
    ee_grant_t  cur;
    ee_data_t   rdata;

    assign seq_ready  = (state == ts_idle);
    assign done_valid = (state == ts_respond);
    assign done_port  = cur.port;
    assign cmd_valid  = !waiting && (state != ts_idle) && (state != ts_respond);

    always_comb begin
        done_rsp.write = cur.req.write;
        done_rsp.err   = nack_err;
        done_rsp.addr  = cur.req.addr;
        done_rsp.rdata = rdata;
    end

    always_comb begin
        cmd      = cmd_idle;
        cmd_byte = 8'h00;
        case (state)
            ts_start, ts_rstart: cmd = cmd_start;
            ts_stop:             cmd = cmd_stop;
            ts_data_rd:          cmd = cmd_rd_byte_nack; // single byte, nack ends it
            ts_ctrl_wr: begin
                cmd      = cmd_wr_byte;
                cmd_byte = {`EE_DEV_CODE, cur.req.addr[10:8], 1'b0};
            end
            ts_ctrl_rd: begin
                cmd      = cmd_wr_byte;
                cmd_byte = {`EE_DEV_CODE, cur.req.addr[10:8], 1'b1};
            end
            ts_addr: begin
                cmd      = cmd_wr_byte;
                cmd_byte = cur.req.addr[7:0];
            end
            ts_data_wr: begin
                cmd      = cmd_wr_byte;
                cmd_byte = cur.req.wdata;
            end
            default: cmd = cmd_idle;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state    <= ts_idle;
            waiting  <= 1'b0;
            nack_err <= 1'b0;
        end else begin
            if (cmd_valid) begin
                waiting <= 1'b1;
            end
            if (state == ts_idle && grant_valid) begin
                state    <= ts_start;
                nack_err <= 1'b0;
            end else if (state == ts_respond) begin
                state <= ts_idle;
            end else if (cmd_done) begin
                waiting <= 1'b0;
                case (state)
                    ts_start:   state <= ts_ctrl_wr;
                    ts_ctrl_wr: state <= ack_seen ? ts_addr : ts_stop;
                    ts_addr: begin
                        if (!ack_seen) begin
                            state <= ts_stop;
                        end else begin
                            state <= cur.req.write ? ts_data_wr : ts_rstart;
                        end
                    end
                    ts_data_wr: state <= ts_stop;
                    ts_rstart:  state <= ts_ctrl_rd;
                    ts_ctrl_rd: state <= ack_seen ? ts_data_rd : ts_stop;
                    ts_data_rd: state <= ts_stop;
                    ts_stop:    state <= ts_respond;
                    default:    state <= state;
                endcase
                if (cmd == cmd_wr_byte && !ack_seen) begin
                    nack_err <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (state == ts_idle && grant_valid) begin
            cur   <= grant;
            rdata <= 8'h00;
        end else if (state == ts_data_rd && cmd_done) begin
            rdata <= rx_byte;
        end
    end

    a_done_when_waiting: assert property (@(posedge CLK) disable iff (RESET)
        cmd_done |-> waiting);

endmodule

//--- design/i2c_bit_engine.sv
`timescale 1ns/1ps
`include "eeprom_config.svh"

module i2c_bit_engine
    import eeprom_pkg::*;
(
    input  logic     CLK,
    input  logic     RESET,
    input  logic     cmd_valid,
    input  bit_cmd_e cmd,
    input  ee_data_t cmd_byte,
    output logic     cmd_done,
    output logic     ack_seen,
    output ee_data_t rx_byte,
    output logic     scl,
    output logic     sda_drive_low,
    input  logic     sda_in
);

    localparam int unsigned DIV   = `EE_SCL_DIV;
    localparam int unsigned CNT_W = $clog2(2 * DIV);
    localparam logic [CNT_W-1:0] LOW_MID  = CNT_W'(DIV / 2);
    localparam logic [CNT_W-1:0] RISE     = CNT_W'(DIV);
    localparam logic [CNT_W-1:0] HIGH_MID = CNT_W'(DIV + DIV / 2);
    localparam logic [CNT_W-1:0] BIT_END  = CNT_W'(2 * DIV - 1);

    bit_state_e       state;
    logic [CNT_W-1:0] cnt;     // position inside one bit time
    logic [2:0]       bit_cnt;
    ee_data_t         shreg;
    logic             is_read;
    logic             master_ack;

    assign rx_byte = shreg;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state         <= bs_idle;
            cnt           <= '0;
            bit_cnt       <= '0;
            scl           <= 1'b1;
            sda_drive_low <= 1'b0;
            cmd_done      <= 1'b0;
            ack_seen      <= 1'b0;
        end else begin
            cmd_done <= 1'b0;
            if (state == bs_idle) begin
                cnt     <= '0;
                bit_cnt <= '0;
                if (cmd_valid) begin
                    case (cmd)
                        cmd_start:   state <= bs_start;
                        cmd_stop:    state <= bs_stop;
                        cmd_wr_byte,
                        cmd_rd_byte_ack,
                        cmd_rd_byte_nack: state <= bs_shift;
                        default:     state <= bs_idle;
                    endcase
                end
            end else begin
                cnt <= (cnt == BIT_END) ? '0 : cnt + 1'b1;
                if (cnt == '0) begin
                    scl <= 1'b0;
                end
                if (cnt == RISE) begin
                    scl <= 1'b1;
                end
                // data moves in the middle of scl low
                if (cnt == LOW_MID) begin
                    case (state)
                        bs_start: sda_drive_low <= 1'b0;
                        bs_stop:  sda_drive_low <= 1'b1;
                        bs_shift: sda_drive_low <= !is_read && !shreg[7];
                        bs_ack:   sda_drive_low <= master_ack; // release for device ack
                        default:  sda_drive_low <= sda_drive_low;
                    endcase
                end
                // start and stop edges, and sampling, in the middle of scl high
                if (cnt == HIGH_MID) begin
                    case (state)
                        bs_start: sda_drive_low <= 1'b1;
                        bs_stop:  sda_drive_low <= 1'b0;
                        bs_ack:   ack_seen <= !sda_in;
                        default:  ack_seen <= ack_seen;
                    endcase
                end
                if (cnt == BIT_END) begin
                    if (state == bs_shift) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= bs_ack;
                        end
                    end else begin
                        state    <= bs_idle;
                        cmd_done <= 1'b1;
                    end
                end
            end
        end
    end

    // write bytes read back their own line, so one shifter serves both directions
    always_ff @(posedge CLK) begin
        if (state == bs_idle && cmd_valid) begin
            shreg      <= cmd_byte;
            is_read    <= (cmd == cmd_rd_byte_ack) || (cmd == cmd_rd_byte_nack);
            master_ack <= (cmd == cmd_rd_byte_ack);
        end else if (state == bs_shift && cnt == HIGH_MID) begin
            shreg <= {shreg[6:0], sda_in};
        end
    end

    // one command at a time
    a_cmd_when_idle: assert property (@(posedge CLK) disable iff (RESET)
        cmd_valid |-> (state == bs_idle));

endmodule

//--- eeprom_ctrl_top.f
+incdir+design
design/eeprom_pkg.sv
design/ee_req_queue.sv
design/ee_bus_arbiter.sv
design/i2c_bit_engine.sv
design/eeprom_txn_seq.sv
design/eeprom_ctrl_top.sv
tb/i2c_eeprom_model.sv
tb/tb_eeprom_ctrl_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_eeprom_ctrl_top \
    -f eeprom_ctrl_top.f

out=$(./obj_dir/Vtb_eeprom_ctrl_top)
echo "$out"

if echo "$out" | grep -qx "Done: no errors"; then
    exit 0
fi
exit 1

//--- tb/i2c_eeprom_model.sv
`timescale 1ns/1ps
`include "eeprom_config.svh"

module i2c_eeprom_model
    import eeprom_pkg::*;
(
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,       // wired-AND line level
    input  logic wp,
    output logic pull_low,
    output int   err_count
);

    typedef enum logic [2:0] {
        m_idle,
        m_ctrl,
        m_addr,
        m_data,
        m_rack,
        m_read,
        m_wait
    } mode_e;

    ee_data_t   mem [2048];
    mode_e      mode;
    logic       prev_scl;
    logic       prev_sda;
    logic [3:0] bit_cnt;    // scl rises seen in the current byte
    ee_data_t   shreg;
    ee_data_t   rbyte;
    ee_data_t   wdata;
    ee_data_t   addr_lo;
    logic [2:0] blk;
    logic       addr_set;
    logic       wr_pending;

    always @(posedge CLK) begin
        if (RESET) begin
            for (int i = 0; i < 2048; i++) begin
                mem[i] <= 8'hFF;
            end
            mode       <= m_idle;
            prev_scl   <= 1'b1;
            prev_sda   <= 1'b1;
            bit_cnt    <= '0;
            pull_low   <= 1'b0;
            addr_set   <= 1'b0;
            wr_pending <= 1'b0;
            blk        <= '0;
            addr_lo    <= '0;
            err_count  <= 0;
        end else begin
            prev_scl <= scl;
            prev_sda <= sda;
            if (scl && prev_scl && prev_sda && !sda) begin
                // start, or repeated start right after a clock pulse
                if (bit_cnt > 1) begin
                    err_count <= err_count + 1;
                end
                mode       <= m_ctrl;
                bit_cnt    <= '0;
                pull_low   <= 1'b0;
                wr_pending <= 1'b0;
            end else if (scl && prev_scl && !prev_sda && sda) begin
                if (mode == m_idle || bit_cnt > 1) begin
                    err_count <= err_count + 1; // stop out of frame
                end
                if (wr_pending) begin
                    mem[{blk, addr_lo}] <= wdata;
                end
                mode       <= m_idle;
                bit_cnt    <= '0;
                pull_low   <= 1'b0;
                addr_set   <= 1'b0;
                wr_pending <= 1'b0;
            end else if (scl && !prev_scl && mode != m_idle) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt < 8) begin
                    shreg <= {shreg[6:0], sda};
                end
                if (mode == m_read && bit_cnt == 8 && !sda) begin
                    err_count <= err_count + 1; // single read must end with nack
                end
            end else if (!scl && prev_scl && mode != m_idle) begin
                if (bit_cnt == 8) begin
                    case (mode)
                        m_ctrl: begin
                            if (shreg[7:4] != `EE_DEV_CODE) begin
                                err_count <= err_count + 1;
                                mode      <= m_wait;
                            end else if (!shreg[0]) begin
                                blk      <= shreg[3:1];
                                mode     <= m_addr;
                                pull_low <= 1'b1;
                            end else if (!addr_set || shreg[3:1] != blk) begin
                                err_count <= err_count + 1; // read without address phase
                                mode      <= m_wait;
                            end else begin
                                rbyte    <= mem[{blk, addr_lo}];
                                mode     <= m_rack;
                                pull_low <= 1'b1;
                            end
                        end
                        m_addr: begin
                            addr_lo  <= shreg;
                            addr_set <= 1'b1;
                            mode     <= m_data;
                            pull_low <= 1'b1;
                        end
                        m_data: begin
                            if (!wp) begin
                                wdata      <= shreg;
                                wr_pending <= 1'b1;
                                pull_low   <= 1'b1;
                            end
                            mode <= m_wait;
                        end
                        m_read: pull_low <= 1'b0; // master ack slot
                        default: begin
                            err_count <= err_count + 1; // page traffic not expected
                            mode      <= m_wait;
                        end
                    endcase
                end else if (bit_cnt == 9) begin
                    bit_cnt <= '0;
                    if (mode == m_rack) begin
                        mode     <= m_read;
                        pull_low <= !rbyte[7];
                    end else begin
                        pull_low <= 1'b0;
                        if (mode == m_read) begin
                            mode <= m_wait;
                        end
                    end
                end else if (mode == m_read && bit_cnt != 0) begin
                    pull_low <= !rbyte[3'(4'd7 - bit_cnt)];
                end
            end
        end
    end

endmodule

//--- tb/tb_eeprom_ctrl_top.sv
`timescale 1ns/1ps
`include "eeprom_config.svh"

module tb_eeprom_ctrl_top
    import eeprom_pkg::*;
();

    localparam int NUM_REQ     = 100;
    localparam int WP_REQ      = 4;
    localparam int POOL        = 8;
    localparam int TXN_TOTAL   = 2 * NUM_REQ + 2 * WP_REQ;
    localparam int CYCLE_LIMIT = TXN_TOTAL * 80 * 2 * `EE_SCL_DIV + 1000;

    logic                     CLK;
    logic                     RESET;
    logic [`EE_NUM_PORTS-1:0] req_valid;
    ee_req_t                  req [`EE_NUM_PORTS];
    logic [`EE_NUM_PORTS-1:0] credit_return;
    logic [`EE_NUM_PORTS-1:0] rsp_valid;
    ee_rsp_t                  rsp [`EE_NUM_PORTS];
    logic                     scl;
    logic                     sda_drive_low;
    logic                     sda_line;
    logic                     model_pull;
    logic                     wp;
    int                       model_errs;

    ee_data_t ref_mem [2048];
    ee_req_t  exp_q [`EE_NUM_PORTS][$]; // outstanding requests in issue order
    int       credits [`EE_NUM_PORTS];
    int       issued [`EE_NUM_PORTS];
    int       returns [`EE_NUM_PORTS];
    int       value_errs;
    int       other_errs;
    int       cycles;

    assign sda_line = !(sda_drive_low || model_pull);

    eeprom_ctrl_top dut_i (
        .CLK           (CLK),
        .RESET         (RESET),
        .req_valid     (req_valid),
        .req           (req),
        .credit_return (credit_return),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .scl           (scl),
        .sda_drive_low (sda_drive_low),
        .sda_in        (sda_line)
    );

    i2c_eeprom_model model_i (
        .CLK       (CLK),
        .RESET     (RESET),
        .scl       (scl),
        .sda       (sda_line),
        .wp        (wp),
        .pull_low  (model_pull),
        .err_count (model_errs)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    task automatic check_rsp(input int port, input ee_rsp_t got, input ee_rsp_t exp);
        if (got.write !== exp.write || got.err !== exp.err || got.addr !== exp.addr ||
            (!exp.write && got.rdata !== exp.rdata)) begin
            value_errs++;
            $display("Error at %0t: port %0d rsp w=%0b err=%0b addr=%h data=%h, exp %0b %0b %h %h",
                     $time, port, got.write, got.err, got.addr, got.rdata,
                     exp.write, exp.err, exp.addr, exp.rdata);
        end
    endtask

    task automatic check_credits(input int port, input int got, input int exp, input string what);
        if (got != exp) begin
            value_errs++;
            $display("Error at %0t: port %0d %s is %0d, expected %0d", $time, port, what, got, exp);
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            value_errs++;
            $display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // blocks 0 1 2 and 4 share each low byte so a dropped address bit aliases
    function automatic ee_addr_t pool_addr(input int idx);
        logic [2:0] blk;
        ee_data_t   lo;
        blk = (idx % 4 == 3) ? 3'd4 : 3'(idx % 4);
        lo  = (idx < 4) ? 8'h3C : 8'hC3;
        return {blk, lo};
    endfunction

    function automatic ee_req_t rand_req();
        ee_req_t r;
        r.write = 1'($urandom % 2);
        r.addr  = pool_addr(int'($urandom % POOL));
        r.wdata = 8'($urandom);
        return r;
    endfunction

    // one falling edge: collect credits and responses, clear the request strobes
    task automatic step();
        ee_req_t r;
        ee_rsp_t e;
        @(negedge CLK);
        req_valid = '0;
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: responses still missing after %0d cycles", cycles);
            $display("Done: errors found");
            $finish;
        end else begin
            for (int p = 0; p < `EE_NUM_PORTS; p++) begin
                if (credit_return[p]) begin
                    credits[p]++;
                    returns[p]++;
                    if (credits[p] > `EE_QUEUE_DEPTH) begin
                        other_errs++;
                        $display("port %0d got more credits back than it spent", p);
                    end
                end
                if (rsp_valid[p]) begin
                    if (exp_q[p].size() == 0) begin
                        other_errs++;
                        $display("port %0d gave a response with no request pending", p);
                    end else begin
                        r       = exp_q[p].pop_front();
                        e.write = r.write;
                        e.err   = r.write && wp;
                        e.addr  = r.addr;
                        e.rdata = ref_mem[r.addr];
                        check_rsp(p, rsp[p], e);
                        if (r.write && !e.err) begin
                            ref_mem[r.addr] = r.wdata;
                        end
                    end
                end
            end
        end
    endtask

    task automatic issue(input int p, input ee_req_t r);
        req_valid[p] = 1'b1;
        req[p]       = r;
        credits[p]--;
        issued[p]++;
        exp_q[p].push_back(r);
    endtask

    task automatic drain();
        while (exp_q[0].size() != 0 || exp_q[1].size() != 0) begin
            step();
        end
    endtask

    initial begin
        ee_req_t r;
        void'($urandom(67));
        RESET      = 1'b1;
        req_valid  = '0;
        req[0]     = '0;
        req[1]     = '0;
        wp         = 1'b0;
        value_errs = 0;
        other_errs = 0;
        cycles     = 0;
        for (int p = 0; p < `EE_NUM_PORTS; p++) begin
            credits[p] = `EE_QUEUE_DEPTH;
            issued[p]  = 0;
            returns[p] = 0;
        end
        for (int a = 0; a < 2048; a++) begin
            ref_mem[a] = 8'hFF;
        end
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;

        step();
        check_level(rsp_valid[0], 1'b0, "rsp_valid[0]");
        check_level(rsp_valid[1], 1'b0, "rsp_valid[1]");
        check_level(credit_return[0], 1'b0, "credit_return[0]");
        check_level(credit_return[1], 1'b0, "credit_return[1]");
        check_level(scl, 1'b1, "scl");
        check_level(sda_drive_low, 1'b0, "sda_drive_low");

        while (issued[0] < NUM_REQ || issued[1] < NUM_REQ) begin
            step();
            for (int p = 0; p < `EE_NUM_PORTS; p++) begin
                if (issued[p] < NUM_REQ && credits[p] > 0 && ($urandom % 2) == 1) begin
                    issue(p, rand_req());
                end
            end
        end
        drain();

        // protected writes must fail and leave the array alone
        wp = 1'b1;
        for (int i = 0; i < WP_REQ; i++) begin
            do step(); while (credits[0] == 0);
            r.write = 1'b1;
            r.addr  = pool_addr(i);
            r.wdata = 8'h5A ^ 8'(i);
            issue(0, r);
        end
        drain();
        step();
        wp = 1'b0;
        for (int i = 0; i < WP_REQ; i++) begin
            do step(); while (credits[1] == 0);
            r.write = 1'b0;
            r.addr  = pool_addr(i);
            r.wdata = 8'h00;
            issue(1, r);
        end
        drain();
        repeat (4) step();

        for (int p = 0; p < `EE_NUM_PORTS; p++) begin
            check_credits(p, credits[p], `EE_QUEUE_DEPTH, "credit count");
            check_credits(p, returns[p], issued[p], "credit return count");
        end
        if (model_errs != 0) begin
            $display("EEPROM model saw %0d bus protocol violations", model_errs);
        end
        $display("Errors: %0d value, %0d other, %0d bus protocol",
                 value_errs, other_errs, model_errs);
        if (value_errs == 0 && other_errs == 0 && model_errs == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
